// File: filelist.f
design/axil_demux_pkg.sv
design/select_fifo.sv
design/axil_demux_write.sv
design/axil_demux_read.sv
design/axil_demux.sv
bench/axil_demux_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = axil_demux_tb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/axil_demux_tb.sv
`timescale 1ns/1ps

module axil_demux_tb;

  localparam int unsigned NUM_PORTS = 4;
  localparam int unsigned MAX_TRANS = 4;
  localparam int unsigned SEL_W     = $clog2(NUM_PORTS);
  localparam int          N_LOAD    = 200;
  // 20 readback, 12 strobe, 8 error and 16 depth transactions
  localparam int          N_TRANS   = 56 + N_LOAD;
  localparam int          TIMEOUT   = 200 * N_TRANS + 100;

  localparam axil_demux_pkg::resp_t OKAY   = 2'b00;
  localparam axil_demux_pkg::resp_t SLVERR = 2'b10;

  typedef struct packed {
    logic [SEL_W-1:0]      port;
    axil_demux_pkg::addr_t addr;
  } addr_cmd_t;

  logic                                      clk_i     = 1'b0;
  logic                                      rst_i     = 1'b1;
  logic                                      hold      = 1'b0;
  axil_demux_pkg::axil_req_t                 sbr_req   = '0;
  logic [SEL_W-1:0]                          aw_select = '0;
  logic [SEL_W-1:0]                          ar_select = '0;
  axil_demux_pkg::axil_rsp_t                 sbr_rsp;
  axil_demux_pkg::axil_req_t [NUM_PORTS-1:0] mgr_req;
  axil_demux_pkg::axil_rsp_t [NUM_PORTS-1:0] mgr_rsp;

  addr_cmd_t               aw_cmd_q [$];
  axil_demux_pkg::w_chan_t w_cmd_q [$];
  addr_cmd_t               ar_cmd_q [$];
  axil_demux_pkg::resp_t   exp_b_q [$];
  axil_demux_pkg::r_chan_t exp_r_q [$];
  addr_cmd_t               aw_next;
  addr_cmd_t               ar_next;
  axil_demux_pkg::w_chan_t w_next;
  axil_demux_pkg::resp_t   exp_b;
  axil_demux_pkg::r_chan_t exp_r;
  axil_demux_pkg::data_t   shadow [NUM_PORTS][16];
  string                   test_name = "reset";
  int                      aw_xfers;
  int                      w_xfers;
  int                      b_xfers;
  int                      ar_xfers;
  int                      r_xfers;
  int                      cycles;
  int                      fail_count;
  int                      mon_p;

  always #5 clk_i = ~clk_i;

  axil_demux #(
    .NUM_PORTS (NUM_PORTS),
    .MAX_TRANS (MAX_TRANS)
  ) UUT (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .sbr_req_i   (sbr_req),
    .aw_select_i (aw_select),
    .ar_select_i (ar_select),
    .sbr_rsp_o   (sbr_rsp),
    .mgr_req_o   (mgr_req),
    .mgr_rsp_i   (mgr_rsp)
  );

  for (genvar g = 0; g < NUM_PORTS; g++) begin : gen_mem
    port_memory #(
      .PORT (g)
    ) mem_model (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .hold_i (hold),
      .req_i  (mgr_req[g]),
      .rsp_o  (mgr_rsp[g])
    );
  end

  // --------------------------------------------------
  // checking helpers
  // --------------------------------------------------
  task automatic report_failure(input string what);
    fail_count++;
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string what, input axil_demux_pkg::data_t expected,
                             input axil_demux_pkg::data_t actual);
    if (expected !== actual) begin
      report_failure($sformatf("mismatch %s (%s): expected %08h, actual %08h",
                               test_name, what, expected, actual));
    end
  endtask

  // expected response of one transaction, and the write applied to the shadow copy
  function automatic axil_demux_pkg::r_chan_t predict(input logic is_write,
      input logic [SEL_W-1:0] port, input axil_demux_pkg::addr_t addr,
      input axil_demux_pkg::w_chan_t w);
    axil_demux_pkg::r_chan_t res;
    int                      b;
    res.resp = addr[11] ? SLVERR : OKAY;
    res.data = shadow[port][addr[5:2]];
    // errored writes leave the memory alone
    if (is_write && !addr[11]) begin
      for (b = 0; b < 4; b++) begin
        if (w.strb[b]) begin
          shadow[port][addr[5:2]][8*b +: 8] = w.data[8*b +: 8];
        end
      end
    end
    return res;
  endfunction

  function automatic axil_demux_pkg::addr_t make_addr(input logic err, input logic [3:0] word);
    return {20'h0, err, 5'h0, word, 2'b00};
  endfunction

  function automatic logic [SEL_W-1:0] rand_port();
    return SEL_W'($urandom_range(NUM_PORTS - 1));
  endfunction

  function automatic axil_demux_pkg::data_t idle_valids();
    axil_demux_pkg::data_t v;
    int                    p;
    v = '0;
    for (p = 0; p < NUM_PORTS; p++) begin
      v[p] = mgr_req[p].aw_valid | mgr_req[p].w_valid | mgr_req[p].ar_valid;
    end
    v[8] = sbr_rsp.b_valid;
    v[9] = sbr_rsp.r_valid;
    return v;
  endfunction

  task automatic queue_write(input logic [SEL_W-1:0] port, input axil_demux_pkg::addr_t addr,
                             input axil_demux_pkg::data_t data, input axil_demux_pkg::strb_t strb);
    addr_cmd_t               cmd;
    axil_demux_pkg::w_chan_t beat;
    axil_demux_pkg::r_chan_t res;
    cmd.port  = port;
    cmd.addr  = addr;
    beat.data = data;
    beat.strb = strb;
    res       = predict(1'b1, port, addr, beat);
    exp_b_q.push_back(res.resp);
    aw_cmd_q.push_back(cmd);
    w_cmd_q.push_back(beat);
  endtask

  task automatic queue_read(input logic [SEL_W-1:0] port, input axil_demux_pkg::addr_t addr);
    addr_cmd_t cmd;
    cmd.port = port;
    cmd.addr = addr;
    exp_r_q.push_back(predict(1'b0, port, addr, '0));
    ar_cmd_q.push_back(cmd);
  endtask

  // returns on a falling edge once every expected response came back
  task automatic wait_done();
    do begin
      @(negedge clk_i);
    end while (exp_b_q.size() + exp_r_q.size() != 0);
  endtask

  // --------------------------------------------------
  // subordinate-side driver
  // --------------------------------------------------
  // prot carries the target port so the monitor can see where each beat lands
  always @(posedge clk_i) begin
    if (rst_i) begin
      sbr_req   <= '0;
      aw_select <= '0;
      ar_select <= '0;
    end else begin
      if (!sbr_req.aw_valid || sbr_rsp.aw_ready) begin
        if (aw_cmd_q.size() > 0 && $urandom_range(3) != 0) begin
          aw_next = aw_cmd_q.pop_front();
          sbr_req.aw_valid <= 1'b1;
          sbr_req.aw.addr  <= aw_next.addr;
          sbr_req.aw.prot  <= 3'(aw_next.port);
          aw_select        <= aw_next.port;
        end else begin
          sbr_req.aw_valid <= 1'b0;
        end
      end
      if (!sbr_req.w_valid || sbr_rsp.w_ready) begin
        if (w_cmd_q.size() > 0 && $urandom_range(3) != 0) begin
          w_next = w_cmd_q.pop_front();
          sbr_req.w_valid <= 1'b1;
          sbr_req.w       <= w_next;
        end else begin
          sbr_req.w_valid <= 1'b0;
        end
      end
      if (!sbr_req.ar_valid || sbr_rsp.ar_ready) begin
        if (ar_cmd_q.size() > 0 && $urandom_range(3) != 0) begin
          ar_next = ar_cmd_q.pop_front();
          sbr_req.ar_valid <= 1'b1;
          sbr_req.ar.addr  <= ar_next.addr;
          sbr_req.ar.prot  <= 3'(ar_next.port);
          ar_select        <= ar_next.port;
        end else begin
          sbr_req.ar_valid <= 1'b0;
        end
      end
      sbr_req.b_ready <= ($urandom_range(3) != 0);
      sbr_req.r_ready <= ($urandom_range(3) != 0);
    end
  end

  // --------------------------------------------------
  // response comparison and depth monitor
  // --------------------------------------------------
  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (sbr_rsp.b_valid && sbr_req.b_ready) begin
        if (exp_b_q.size() == 0) begin
          report_failure("a write response arrived with no write outstanding");
        end else begin
          exp_b = exp_b_q.pop_front();
          check_value("b resp", 32'(exp_b), 32'(sbr_rsp.b.resp));
        end
      end
      if (sbr_rsp.r_valid && sbr_req.r_ready) begin
        if (exp_r_q.size() == 0) begin
          report_failure("a read response arrived with no read outstanding");
        end else begin
          exp_r = exp_r_q.pop_front();
          check_value("r data", exp_r.data, sbr_rsp.r.data);
          check_value("r resp", 32'(exp_r.resp), 32'(sbr_rsp.r.resp));
        end
      end
      for (mon_p = 0; mon_p < NUM_PORTS; mon_p++) begin
        if (mgr_req[mon_p].aw_valid && mgr_rsp[mon_p].aw_ready) begin
          aw_xfers++;
          check_value("aw port", 32'(mon_p), 32'(mgr_req[mon_p].aw.prot));
        end
        if (mgr_req[mon_p].w_valid && mgr_rsp[mon_p].w_ready) w_xfers++;
        if (mgr_rsp[mon_p].b_valid && mgr_req[mon_p].b_ready) b_xfers++;
        if (mgr_req[mon_p].ar_valid && mgr_rsp[mon_p].ar_ready) begin
          ar_xfers++;
          check_value("ar port", 32'(mon_p), 32'(mgr_req[mon_p].ar.prot));
        end
        if (mgr_rsp[mon_p].r_valid && mgr_req[mon_p].r_ready) r_xfers++;
      end
      if (w_xfers - b_xfers > int'(MAX_TRANS)) begin
        report_failure("more writes are waiting for B than the demux may track");
      end
      if (aw_xfers - w_xfers > int'(MAX_TRANS)) begin
        report_failure("more addresses are waiting for W data than the demux may track");
      end
      if (ar_xfers - r_xfers > int'(MAX_TRANS)) begin
        report_failure("more reads are waiting for R than the demux may track");
      end
    end
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT) begin
      report_failure($sformatf("timeout, the run was still busy after %0d cycles", TIMEOUT));
    end
  end

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    int   p;
    int   q;
    int   n;
    logic err;
    void'($urandom(32'he806_267f));
    // port in the top byte, word index in the low byte
    for (p = 0; p < NUM_PORTS; p++) begin
      for (n = 0; n < 16; n++) begin
        shadow[p][n] = {8'(p), 20'h0, 4'(n)};
      end
    end
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;

    test_name = "idle after reset";
    repeat (4) begin
      @(negedge clk_i);
      check_value("valids", '0, idle_valids());
    end

    test_name = "write then read back";
    for (p = 0; p < NUM_PORTS; p++) begin
      queue_write(SEL_W'(p), make_addr(1'b0, 4'(3 + p)), {8'ha5, 8'(p), 16'h5a5a}, 4'hf);
      wait_done();
      for (q = 0; q < NUM_PORTS; q++) begin
        queue_read(SEL_W'(q), make_addr(1'b0, 4'(3 + p)));
      end
      wait_done();
    end

    // reads and writes are not ordered against each other, so the reads wait
    test_name = "partial strobes";
    for (p = 0; p < NUM_PORTS; p++) begin
      queue_write(SEL_W'(p), make_addr(1'b0, 4'd7), 32'h1122_3344, 4'b0101);
      queue_write(SEL_W'(p), make_addr(1'b0, 4'd7), 32'hdead_beef, 4'b1000);
    end
    wait_done();
    for (p = 0; p < NUM_PORTS; p++) begin
      queue_read(SEL_W'(p), make_addr(1'b0, 4'd7));
    end
    wait_done();

    // reads stay in words 0 to 7 and writes in 8 to 15 so both orders agree
    test_name = "mixed load";
    for (n = 0; n < N_LOAD; n++) begin
      err = ($urandom_range(7) == 0);
      if ($urandom_range(1) == 1) begin
        queue_write(rand_port(), make_addr(err, 4'(8 + $urandom_range(7))), $urandom(),
                    4'($urandom_range(15)));
      end else begin
        queue_read(rand_port(), make_addr(err, 4'($urandom_range(7))));
      end
    end
    wait_done();

    test_name = "error responses";
    for (p = 0; p < NUM_PORTS; p++) begin
      queue_write(SEL_W'(p), make_addr(1'b1, 4'd9), 32'hffff_ffff, 4'hf);
      queue_read(SEL_W'(p), make_addr(1'b1, 4'd9));
    end
    wait_done();

    test_name = "depth limit";
    @(posedge clk_i);
    hold <= 1'b1;
    @(negedge clk_i);
    // enough writes to fill both the W and the B select FIFO
    for (n = 0; n < 10; n++) begin
      queue_write(rand_port(), make_addr(1'b0, 4'(6 + n)), $urandom(), 4'hf);
    end
    for (n = 0; n < 6; n++) begin
      queue_read(rand_port(), make_addr(1'b0, 4'(n)));
    end
    while ((w_xfers - b_xfers) < int'(MAX_TRANS) || (aw_xfers - w_xfers) < int'(MAX_TRANS) ||
           (ar_xfers - r_xfers) < int'(MAX_TRANS)) begin
      @(negedge clk_i);
    end
    repeat (20) @(negedge clk_i);
    @(posedge clk_i);
    hold <= 1'b0;
    wait_done();

    if (fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// --------------------------------------------------
// memory model behind one manager-side port
// --------------------------------------------------
module port_memory #(
  parameter int unsigned PORT = 0
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      hold_i,
  input  axil_demux_pkg::axil_req_t req_i,
  output axil_demux_pkg::axil_rsp_t rsp_o
);

  axil_demux_pkg::data_t   mem [16];
  axil_demux_pkg::addr_t   aw_q [$];
  axil_demux_pkg::w_chan_t w_q [$];
  axil_demux_pkg::resp_t   b_q [$];
  axil_demux_pkg::r_chan_t r_q [$];
  axil_demux_pkg::addr_t   addr;
  axil_demux_pkg::w_chan_t beat;
  axil_demux_pkg::r_chan_t rd;
  int                      i;

  always @(posedge clk_i) begin
    if (rst_i) begin
      rsp_o <= '0;
      for (i = 0; i < 16; i++) begin
        mem[i] = {8'(PORT), 20'h0, 4'(i)};
      end
    end else begin
      if (req_i.aw_valid && rsp_o.aw_ready) begin
        aw_q.push_back(req_i.aw.addr);
      end
      if (req_i.w_valid && rsp_o.w_ready) begin
        w_q.push_back(req_i.w);
      end
      // bit 11 marks the error region
      if (req_i.ar_valid && rsp_o.ar_ready) begin
        rd.data = mem[req_i.ar.addr[5:2]];
        rd.resp = req_i.ar.addr[11] ? 2'b10 : 2'b00;
        r_q.push_back(rd);
      end
      if (aw_q.size() > 0 && w_q.size() > 0) begin
        addr = aw_q.pop_front();
        beat = w_q.pop_front();
        if (!addr[11]) begin
          for (i = 0; i < 4; i++) begin
            if (beat.strb[i]) begin
              mem[addr[5:2]][8*i +: 8] = beat.data[8*i +: 8];
            end
          end
        end
        b_q.push_back(addr[11] ? 2'b10 : 2'b00);
      end
      rsp_o.aw_ready <= ($urandom_range(3) != 0);
      rsp_o.w_ready  <= ($urandom_range(3) != 0);
      rsp_o.ar_ready <= ($urandom_range(3) != 0);
      // responses leave in order after a random wait
      if (rsp_o.b_valid && req_i.b_ready) begin
        rsp_o.b_valid <= 1'b0;
      end else if (!rsp_o.b_valid && b_q.size() > 0 && !hold_i && $urandom_range(2) == 0) begin
        rsp_o.b_valid <= 1'b1;
        rsp_o.b.resp  <= b_q.pop_front();
      end
      if (rsp_o.r_valid && req_i.r_ready) begin
        rsp_o.r_valid <= 1'b0;
      end else if (!rsp_o.r_valid && r_q.size() > 0 && !hold_i && $urandom_range(2) == 0) begin
        rsp_o.r_valid <= 1'b1;
        rsp_o.r       <= r_q.pop_front();
      end
    end
  end

endmodule

// File: design/axil_demux.sv
`timescale 1ns/1ps

module axil_demux #(
  parameter int unsigned NUM_PORTS = 4,
  parameter int unsigned MAX_TRANS = 4,
  localparam int unsigned SEL_W    = $clog2(NUM_PORTS)
) (
  input  logic                                      clk_i,
  input  logic                                      rst_i,
  input  axil_demux_pkg::axil_req_t                 sbr_req_i,
  input  logic [SEL_W-1:0]                          aw_select_i,
  input  logic [SEL_W-1:0]                          ar_select_i,
  output axil_demux_pkg::axil_rsp_t                 sbr_rsp_o,
  output axil_demux_pkg::axil_req_t [NUM_PORTS-1:0] mgr_req_o,
  input  axil_demux_pkg::axil_rsp_t [NUM_PORTS-1:0] mgr_rsp_i
);

  axil_demux_pkg::aw_chan_t [NUM_PORTS-1:0] mgr_aw;
  logic [NUM_PORTS-1:0]                     mgr_aw_valid;
  logic [NUM_PORTS-1:0]                     mgr_aw_ready;
  axil_demux_pkg::w_chan_t  [NUM_PORTS-1:0] mgr_w;
  logic [NUM_PORTS-1:0]                     mgr_w_valid;
  logic [NUM_PORTS-1:0]                     mgr_w_ready;
  axil_demux_pkg::b_chan_t  [NUM_PORTS-1:0] mgr_b;
  logic [NUM_PORTS-1:0]                     mgr_b_valid;
  logic [NUM_PORTS-1:0]                     mgr_b_ready;
  axil_demux_pkg::ar_chan_t [NUM_PORTS-1:0] mgr_ar;
  logic [NUM_PORTS-1:0]                     mgr_ar_valid;
  logic [NUM_PORTS-1:0]                     mgr_ar_ready;
  axil_demux_pkg::r_chan_t  [NUM_PORTS-1:0] mgr_r;
  logic [NUM_PORTS-1:0]                     mgr_r_valid;
  logic [NUM_PORTS-1:0]                     mgr_r_ready;

  axil_demux_write #(
    .NUM_PORTS (NUM_PORTS),
    .MAX_TRANS (MAX_TRANS)
  ) write_path (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .aw_i           (sbr_req_i.aw),
    .aw_valid_i     (sbr_req_i.aw_valid),
    .aw_select_i    (aw_select_i),
    .aw_ready_o     (sbr_rsp_o.aw_ready),
    .w_i            (sbr_req_i.w),
    .w_valid_i      (sbr_req_i.w_valid),
    .w_ready_o      (sbr_rsp_o.w_ready),
    .b_o            (sbr_rsp_o.b),
    .b_valid_o      (sbr_rsp_o.b_valid),
    .b_ready_i      (sbr_req_i.b_ready),
    .mgr_aw_o       (mgr_aw),
    .mgr_aw_valid_o (mgr_aw_valid),
    .mgr_aw_ready_i (mgr_aw_ready),
    .mgr_w_o        (mgr_w),
    .mgr_w_valid_o  (mgr_w_valid),
    .mgr_w_ready_i  (mgr_w_ready),
    .mgr_b_i        (mgr_b),
    .mgr_b_valid_i  (mgr_b_valid),
    .mgr_b_ready_o  (mgr_b_ready)
  );

  axil_demux_read #(
    .NUM_PORTS (NUM_PORTS),
    .MAX_TRANS (MAX_TRANS)
  ) read_path (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .ar_i           (sbr_req_i.ar),
    .ar_valid_i     (sbr_req_i.ar_valid),
    .ar_select_i    (ar_select_i),
    .ar_ready_o     (sbr_rsp_o.ar_ready),
    .r_o            (sbr_rsp_o.r),
    .r_valid_o      (sbr_rsp_o.r_valid),
    .r_ready_i      (sbr_req_i.r_ready),
    .mgr_ar_o       (mgr_ar),
    .mgr_ar_valid_o (mgr_ar_valid),
    .mgr_ar_ready_i (mgr_ar_ready),
    .mgr_r_i        (mgr_r),
    .mgr_r_valid_i  (mgr_r_valid),
    .mgr_r_ready_o  (mgr_r_ready)
  );

  // repack per-channel arrays into the manager-side port structs
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_port
    assign mgr_req_o[i].aw       = mgr_aw[i];
    assign mgr_req_o[i].aw_valid = mgr_aw_valid[i];
    assign mgr_req_o[i].w        = mgr_w[i];
    assign mgr_req_o[i].w_valid  = mgr_w_valid[i];
    assign mgr_req_o[i].b_ready  = mgr_b_ready[i];
    assign mgr_req_o[i].ar       = mgr_ar[i];
    assign mgr_req_o[i].ar_valid = mgr_ar_valid[i];
    assign mgr_req_o[i].r_ready  = mgr_r_ready[i];

    assign mgr_aw_ready[i] = mgr_rsp_i[i].aw_ready;
    assign mgr_w_ready[i]  = mgr_rsp_i[i].w_ready;
    assign mgr_b[i]        = mgr_rsp_i[i].b;
    assign mgr_b_valid[i]  = mgr_rsp_i[i].b_valid;
    assign mgr_ar_ready[i] = mgr_rsp_i[i].ar_ready;
    assign mgr_r[i]        = mgr_rsp_i[i].r;
    assign mgr_r_valid[i]  = mgr_rsp_i[i].r_valid;
  end

endmodule

// File: design/axil_demux_read.sv
`timescale 1ns/1ps

module axil_demux_read #(
  parameter int unsigned NUM_PORTS = 4,
  parameter int unsigned MAX_TRANS = 4,
  localparam int unsigned SEL_W    = $clog2(NUM_PORTS)
) (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  // subordinate side
  input  axil_demux_pkg::ar_chan_t                 ar_i,
  input  logic                                     ar_valid_i,
  input  logic [SEL_W-1:0]                         ar_select_i,
  output logic                                     ar_ready_o,
  output axil_demux_pkg::r_chan_t                  r_o,
  output logic                                     r_valid_o,
  input  logic                                     r_ready_i,
  // manager side
  output axil_demux_pkg::ar_chan_t [NUM_PORTS-1:0] mgr_ar_o,
  output logic [NUM_PORTS-1:0]                     mgr_ar_valid_o,
  input  logic [NUM_PORTS-1:0]                     mgr_ar_ready_i,
  input  axil_demux_pkg::r_chan_t  [NUM_PORTS-1:0] mgr_r_i,
  input  logic [NUM_PORTS-1:0]                     mgr_r_valid_i,
  output logic [NUM_PORTS-1:0]                     mgr_r_ready_o
);

  logic             r_fifo_push;
  logic             r_fifo_full;
  logic             r_fifo_empty;
  logic [SEL_W-1:0] r_select;
  logic             r_xfer;

  // --------------------------------------------------
  // AR channel
  // --------------------------------------------------
  // only offered while there is room to record the target port
  assign ar_ready_o  = ~r_fifo_full & mgr_ar_ready_i[ar_select_i];
  assign r_fifo_push = ar_valid_i & ar_ready_o;

  select_fifo #(
    .DEPTH (MAX_TRANS),
    .WIDTH (SEL_W)
  ) r_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (r_fifo_push),
    .data_i  (ar_select_i),
    .pop_i   (r_xfer),
    .data_o  (r_select),
    .full_o  (r_fifo_full),
    .empty_o (r_fifo_empty)
  );

  // --------------------------------------------------
  // R channel
  // --------------------------------------------------
  // responses come back in AR order from the head port
  assign r_o       = r_fifo_empty ? '0 : mgr_r_i[r_select];
  assign r_valid_o = ~r_fifo_empty & mgr_r_valid_i[r_select];
  assign r_xfer    = r_valid_o & r_ready_i;

  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_port
    assign mgr_ar_o[i]       = ar_i;
    assign mgr_ar_valid_o[i] = ar_valid_i & ~r_fifo_full & (ar_select_i == SEL_W'(i));
    assign mgr_r_ready_o[i]  = ~r_fifo_empty & r_ready_i & (r_select == SEL_W'(i));
  end

endmodule

// File: design/axil_demux_write.sv
`timescale 1ns/1ps

module axil_demux_write #(
  parameter int unsigned NUM_PORTS = 4,
  parameter int unsigned MAX_TRANS = 4,
  localparam int unsigned SEL_W    = $clog2(NUM_PORTS)
) (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  // subordinate side
  input  axil_demux_pkg::aw_chan_t                 aw_i,
  input  logic                                     aw_valid_i,
  input  logic [SEL_W-1:0]                         aw_select_i,
  output logic                                     aw_ready_o,
  input  axil_demux_pkg::w_chan_t                  w_i,
  input  logic                                     w_valid_i,
  output logic                                     w_ready_o,
  output axil_demux_pkg::b_chan_t                  b_o,
  output logic                                     b_valid_o,
  input  logic                                     b_ready_i,
  // manager side
  output axil_demux_pkg::aw_chan_t [NUM_PORTS-1:0] mgr_aw_o,
  output logic [NUM_PORTS-1:0]                     mgr_aw_valid_o,
  input  logic [NUM_PORTS-1:0]                     mgr_aw_ready_i,
  output axil_demux_pkg::w_chan_t  [NUM_PORTS-1:0] mgr_w_o,
  output logic [NUM_PORTS-1:0]                     mgr_w_valid_o,
  input  logic [NUM_PORTS-1:0]                     mgr_w_ready_i,
  input  axil_demux_pkg::b_chan_t  [NUM_PORTS-1:0] mgr_b_i,
  input  logic [NUM_PORTS-1:0]                     mgr_b_valid_i,
  output logic [NUM_PORTS-1:0]                     mgr_b_ready_o
);

  logic             lock_d;
  logic             lock_q;
  logic             w_fifo_push;
  logic             w_fifo_full;
  logic             w_fifo_empty;
  logic [SEL_W-1:0] w_select;
  logic             w_beat_ok;
  logic             w_xfer;
  logic             b_fifo_full;
  logic             b_fifo_empty;
  logic [SEL_W-1:0] b_select;
  logic             b_xfer;

  // --------------------------------------------------
  // AW channel
  // --------------------------------------------------
  always_comb begin
    lock_d         = lock_q;
    aw_ready_o     = 1'b0;
    mgr_aw_valid_o = '0;
    w_fifo_push    = 1'b0;
    if (lock_q) begin
      // select already queued, keep presenting until accepted
      mgr_aw_valid_o[aw_select_i] = 1'b1;
      if (mgr_aw_ready_i[aw_select_i]) begin
        aw_ready_o = 1'b1;
        lock_d     = 1'b0;
      end
    end else if (aw_valid_i && !w_fifo_full) begin
      w_fifo_push                 = 1'b1;
      mgr_aw_valid_o[aw_select_i] = 1'b1;
      if (mgr_aw_ready_i[aw_select_i]) begin
        aw_ready_o = 1'b1;
      end else begin
        lock_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
    end
  end

  select_fifo #(
    .DEPTH (MAX_TRANS),
    .WIDTH (SEL_W)
  ) w_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (w_fifo_push),
    .data_i  (aw_select_i),
    .pop_i   (w_xfer),
    .data_o  (w_select),
    .full_o  (w_fifo_full),
    .empty_o (w_fifo_empty)
  );

  // --------------------------------------------------
  // W channel
  // --------------------------------------------------
  // a beat needs a target port and room to remember it for B
  assign w_beat_ok = ~w_fifo_empty & ~b_fifo_full;
  assign w_ready_o = w_beat_ok & mgr_w_ready_i[w_select];
  assign w_xfer    = w_valid_i & w_ready_o;

  select_fifo #(
    .DEPTH (MAX_TRANS),
    .WIDTH (SEL_W)
  ) b_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (w_xfer),
    .data_i  (w_select),
    .pop_i   (b_xfer),
    .data_o  (b_select),
    .full_o  (b_fifo_full),
    .empty_o (b_fifo_empty)
  );

  // --------------------------------------------------
  // B channel
  // --------------------------------------------------
  assign b_o       = b_fifo_empty ? '0 : mgr_b_i[b_select];
  assign b_valid_o = ~b_fifo_empty & mgr_b_valid_i[b_select];
  assign b_xfer    = b_valid_o & b_ready_i;

  // payloads go everywhere, valids and readies only to the selected port
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_port
    assign mgr_aw_o[i]      = aw_i;
    assign mgr_w_o[i]       = w_i;
    assign mgr_w_valid_o[i] = w_beat_ok & w_valid_i & (w_select == SEL_W'(i));
    assign mgr_b_ready_o[i] = ~b_fifo_empty & b_ready_i & (b_select == SEL_W'(i));
  end

endmodule

// File: design/select_fifo.sv
`timescale 1ns/1ps

module select_fifo #(
  parameter int unsigned DEPTH = 4,
  parameter int unsigned WIDTH = 2
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             full_o,
  output logic             empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  // wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // head entry comes straight from the storage registers
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: design/axil_demux_pkg.sv
package axil_demux_pkg;

  // --------------------------------------------------
  // bus widths
  // --------------------------------------------------
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [1:0]        resp_t;

  // --------------------------------------------------
  // channel payloads
  // --------------------------------------------------
  typedef struct packed {
    addr_t      addr;
    logic [2:0] prot;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_chan_t;

  typedef struct packed {
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    addr_t      addr;
    logic [2:0] prot;
  } ar_chan_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
  } r_chan_t;

  // manager to subordinate direction
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axil_req_t;

  // subordinate to manager direction
  typedef struct packed {
    logic     aw_ready;
    logic     w_ready;
    b_chan_t  b;
    logic     b_valid;
    logic     ar_ready;
    r_chan_t  r;
    logic     r_valid;
  } axil_rsp_t;

endpackage
